// File: design/iccm_pkg.sv
//**************************************
// Shared types for the banked ICCM
// Word, payload and fetch widths, plus the request and bank
// control bundles passed between steering, redundancy and banks
//**************************************

package iccm_pkg;

   //**************************************
   // Data widths
   //**************************************

   // One bank entry, 32 data bits and 7 check bits
   typedef logic [38:0] bank_word_t;

   // Two bank words, low word in [38:0]
   typedef logic [77:0] wr_data_t;

   // Fetch data after the halfword shift
   typedef logic [63:0] rd_data_t;

   // Write size code
   typedef logic [2:0]  wr_size_t;

   localparam wr_size_t WR_SIZE_DW = 3'd3;   // Double word, all else is a word

   //**************************************
   // Bundles
   //**************************************

   // Access request as seen by steering and redundancy
   typedef struct packed {
      logic       wren;              // Write strobe
      logic       rden;              // Read strobe
      logic       correct_ecc;       // Correction cycle, word splat in both halves
      logic       correction_state;  // Core replaying a corrected fetch
      wr_size_t   wr_size;
      wr_data_t   wr_data;
   } wr_req_t;

   // Per bank strobes from steering
   typedef struct packed {
      logic clken;   // Bank active this cycle
      logic wren;    // Write, else read
   } bank_ctl_t;

endpackage

// File: design/iccm_bank_ram.sv
//**************************************
// Single port ICCM bank of 39-bit words
// Writes or registers a read while clken is high,
// output holds the last read otherwise
//**************************************

`timescale 1ns/1ps

module iccm_bank_ram #(
   parameter int ROW_BITS = 8                        // Row address width
) (
   input  logic                 clk,
   input  iccm_pkg::bank_ctl_t  ctl,                  // Clock enable and write strobe
   input  logic [ROW_BITS-1:0]  addr,                 // Row within the bank
   input  iccm_pkg::bank_word_t wr_data,
   output iccm_pkg::bank_word_t dout                  // Registered read word
);

   localparam int DEPTH = 1 << ROW_BITS;

   // Storage array, reached by name from the testbench
   iccm_pkg::bank_word_t mem [DEPTH];

   // Write first priority, a write cycle leaves dout alone
   always_ff @(posedge clk) begin
      if (ctl.clken) begin
         if (ctl.wren) begin
            mem[addr] <= wr_data;
         end else begin
            dout <= mem[addr];                        // Read lands next cycle
         end
      end
   end

endmodule

// File: design/iccm_redundancy.sv
//**************************************
// Hard fault redundancy for the ICCM banks
// Two CAM rows of word address, data and valid with an LRU
// pick; a correction cycle loads a row, later reads that hit
// are served from the row and later writes keep it current
//**************************************

`timescale 1ns/1ps

module iccm_redundancy #(
   parameter int ICCM_BITS = 12,                      // Byte address width
   parameter int NUM_BANKS = 4                        // 4 or 8
) (
   input  logic                                    clk,
   input  logic                                    reset,
   input  iccm_pkg::wr_req_t                       req,
   input  logic [ICCM_BITS-1:1]                    rw_addr,    // Access halfword address
   input  logic [ICCM_BITS-1:1]                    inc_addr,   // Second word address from steering
   output logic [NUM_BANKS-1:0]                    red_sel,    // Registered, aligned with bank dout
   output iccm_pkg::bank_word_t [NUM_BANKS-1:0]    red_data    // Replacement word per bank
);

   localparam int BANK_BITS = $clog2(NUM_BANKS);
   localparam int BANK_HI   = BANK_BITS + 1;          // Bank field is [BANK_HI:2]

   logic [1:0][ICCM_BITS-1:2]           red_addr;     // Word address per row
   iccm_pkg::bank_word_t [1:0]          red_word;     // Protected copy per row
   logic [1:0]                          red_valid;
   logic                                lru;          // Row to replace next

   logic [1:0][NUM_BANKS-1:0]           sel_now;      // Row hit per bank, this cycle
   logic [1:0][NUM_BANKS-1:0]           sel_q;        // Same, one cycle later
   logic [1:0]                          row_load;     // Correction capture
   logic [1:0]                          row_refresh;  // Later write hit
   iccm_pkg::bank_word_t [1:0]          refresh_word;
   logic                                is_dw;
   logic                                lru_en;
   logic                                lru_in;

   assign is_dw = (req.wr_size == iccm_pkg::WR_SIZE_DW);

   //**************************************
   // Address match
   //**************************************

   for (genvar r = 0; r < 2; r++) begin : g_row
      for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
         // Either access word landing in bank i on this row
         assign sel_now[r][i] = red_valid[r] &
            (((rw_addr[ICCM_BITS-1:2] == red_addr[r]) &
              (rw_addr[BANK_HI:2] == BANK_BITS'(i))) |
             ((inc_addr[ICCM_BITS-1:2] == red_addr[r]) &
              (inc_addr[BANK_HI:2] == BANK_BITS'(i))));
      end

      // Same double word, and same word unless the write covers both
      assign row_refresh[r] = req.wren & red_valid[r] &
                              (rw_addr[ICCM_BITS-1:3] == red_addr[r][ICCM_BITS-1:3]) &
                              ((rw_addr[2] == red_addr[r][2]) | is_dw);

      // High half when the stored word is the upper one of the write
      assign refresh_word[r] =
         (((rw_addr[2] == red_addr[r][2]) & rw_addr[2]) | (red_addr[r][2] & is_dw)) ?
         req.wr_data[77:39] : req.wr_data[38:0];
   end

   // Correction goes to the LRU row
   assign row_load[0] = req.correct_ecc & ~lru;
   assign row_load[1] = req.correct_ecc & lru;

   //**************************************
   // LRU update
   //**************************************

   // Hit during replay pushes LRU to the other row
   assign lru_en = req.correct_ecc |
                   (((|sel_now[0]) | (|sel_now[1])) & req.rden & req.correction_state);
   assign lru_in = req.correct_ecc ? ~lru : (|sel_now[0]);

   always_ff @(posedge clk) begin
      if (reset) begin
         red_valid <= '0;
         lru       <= 1'b0;
         sel_q     <= '0;
      end else begin
         for (int r = 0; r < 2; r++) begin
            if (row_load[r]) begin
               red_valid[r] <= 1'b1;                  // Sticky once loaded
            end
         end
         if (lru_en) begin
            lru <= lru_in;
         end
         sel_q <= sel_now;                            // Matches bank read latency
      end
   end

   // Row contents, qualified by red_valid
   always_ff @(posedge clk) begin
      for (int r = 0; r < 2; r++) begin
         if (row_load[r]) begin
            red_addr[r] <= rw_addr[ICCM_BITS-1:2];
         end
         if (row_load[r] | row_refresh[r]) begin
            red_word[r] <= refresh_word[r];           // Either half on a splat
         end
      end
   end

   //**************************************
   // Read substitution
   //**************************************

   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_out
      assign red_sel[i]  = sel_q[0][i] | sel_q[1][i];
      assign red_data[i] = sel_q[1][i] ? red_word[1] : red_word[0];
   end

   // Duplicate rows would make the substitution ambiguous
   a_rows_unique: assert property (@(posedge clk) disable iff (reset)
      (red_valid == 2'b11) |-> (red_addr[0] != red_addr[1]));

endmodule

// File: design/iccm_mem.sv
//**************************************
// ICCM bank steering and read path
// Splits each access over the rw_addr bank and the next
// bank, then joins two substituted bank words into a
// halfword aligned 64-bit fetch one cycle later
//**************************************

`timescale 1ns/1ps

module iccm_mem #(
   parameter  int ICCM_BITS          = 12,            // Byte address width
   parameter  int NUM_BANKS          = 4,             // 4 or 8
   localparam int BANK_BITS          = $clog2(NUM_BANKS),
   localparam int ICCM_BANK_INDEX_LO = BANK_BITS + 2, // Lowest row address bit
   localparam int ROW_BITS           = ICCM_BITS - ICCM_BANK_INDEX_LO
) (
   input  logic                                  clk,
   input  logic                                  reset,
   input  iccm_pkg::wr_req_t                     req,
   input  logic [ICCM_BITS-1:1]                  rw_addr,       // Halfword address
   output logic [ICCM_BITS-1:1]                  inc_addr,      // Second word address
   output iccm_pkg::bank_ctl_t [NUM_BANKS-1:0]   bank_ctl,
   output logic [NUM_BANKS-1:0][ROW_BITS-1:0]    bank_addr,
   output iccm_pkg::bank_word_t [NUM_BANKS-1:0]  bank_wr_data,
   input  iccm_pkg::bank_word_t [NUM_BANKS-1:0]  bank_dout,
   input  logic [NUM_BANKS-1:0]                  red_sel,       // Use redundant copy
   input  iccm_pkg::bank_word_t [NUM_BANKS-1:0]  red_data,
   output iccm_pkg::rd_data_t                    rd_data,
   output iccm_pkg::wr_data_t                    rd_data_ecc    // Raw pair for ECC check
);

   localparam int BANK_HI = BANK_BITS + 1;            // Bank field is [BANK_HI:2]

   logic [1:0]                          addr_incr;
   logic [NUM_BANKS-1:0]                hit_lo;       // Bank of rw_addr
   logic [NUM_BANKS-1:0]                hit_hi;       // Bank of inc_addr
   logic [NUM_BANKS-1:0]                wren_bank;
   logic [NUM_BANKS-1:0]                rden_bank;
   iccm_pkg::bank_word_t [NUM_BANKS-1:0] dout_fn;     // After substitution
   logic [BANK_HI:1]                    rd_addr_lo_q;
   logic [BANK_HI:2]                    rd_addr_hi_q;
   iccm_pkg::bank_word_t                rd_lo;
   iccm_pkg::bank_word_t                rd_hi;
   iccm_pkg::rd_data_t                  rd_pair;

   //**************************************
   // Steering
   //**************************************

   // One halfword for a word, two for a double word
   assign addr_incr = (req.wr_size == iccm_pkg::WR_SIZE_DW) ? 2'd2 : 2'd1;
   assign inc_addr  = rw_addr + (ICCM_BITS-1)'(addr_incr);

   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
      assign hit_lo[i]    = (rw_addr[BANK_HI:2] == BANK_BITS'(i));
      assign hit_hi[i]    = (inc_addr[BANK_HI:2] == BANK_BITS'(i));
      assign wren_bank[i] = req.wren & (hit_lo[i] | hit_hi[i]);
      assign rden_bank[i] = req.rden & (hit_lo[i] | hit_hi[i]);

      assign bank_ctl[i] = '{clken: wren_bank[i] | rden_bank[i], wren: wren_bank[i]};

      // Writes stay on the rw_addr row
      assign bank_addr[i] = (~wren_bank[i] & hit_hi[i]) ?
                            inc_addr[ICCM_BITS-1:ICCM_BANK_INDEX_LO] :
                            rw_addr[ICCM_BITS-1:ICCM_BANK_INDEX_LO];

      // Even banks take the low word, odd banks the high word
      if (i % 2 == 0) begin : g_even
         assign bank_wr_data[i] = req.wr_data[38:0];
      end else begin : g_odd
         assign bank_wr_data[i] = req.wr_data[77:39];
      end

      assign dout_fn[i] = red_sel[i] ? red_data[i] : bank_dout[i];   // Hard fault bypass
   end

   //**************************************
   // Read path
   //**************************************

   // Loaded every cycle, bit 1 kept for the shift
   always_ff @(posedge clk) begin
      if (reset) begin
         rd_addr_lo_q <= '0;
         rd_addr_hi_q <= '0;
      end else begin
         rd_addr_lo_q <= rw_addr[BANK_HI:1];
         rd_addr_hi_q <= inc_addr[BANK_HI:2];
      end
   end

   assign rd_lo   = dout_fn[rd_addr_lo_q[BANK_HI:2]];
   assign rd_hi   = dout_fn[rd_addr_hi_q];
   assign rd_pair = {rd_hi[31:0], rd_lo[31:0]};       // Data halves only

   // Odd halfword start drops the low halfword, zero fill on top
   assign rd_data     = rd_addr_lo_q[1] ? {16'h0000, rd_pair[63:16]} : rd_pair;
   assign rd_data_ecc = {rd_hi, rd_lo};

   // Upstream issues one access type per cycle
   a_no_wr_rd: assert property (@(posedge clk) disable iff (reset)
      !(req.wren && req.rden));

   // Correction always comes as a write
   a_correct_wr: assert property (@(posedge clk) disable iff (reset)
      req.correct_ecc |-> req.wren);

endmodule

// File: design/iccm_top.sv
//**************************************
// ICCM top level
// Packs the request, ties steering and redundancy to the
// bank RAMs and sets the address width and bank count
//**************************************

`timescale 1ns/1ps

module iccm_top #(
   parameter int ICCM_BITS = 12,                      // 4 KB, 11 and 13 also work
   parameter int NUM_BANKS = 4                        // 4 or 8
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  wren,
   input  logic                  rden,
   input  logic [ICCM_BITS-1:1]  rw_addr,              // Halfword address
   input  logic                  correct_ecc,
   input  logic                  correction_state,
   input  iccm_pkg::wr_size_t    wr_size,
   input  iccm_pkg::wr_data_t    wr_data,
   output iccm_pkg::rd_data_t    rd_data,
   output iccm_pkg::wr_data_t    rd_data_ecc
);

   localparam int ICCM_BANK_INDEX_LO = $clog2(NUM_BANKS) + 2;
   localparam int ROW_BITS           = ICCM_BITS - ICCM_BANK_INDEX_LO;

   iccm_pkg::wr_req_t                       req;
   logic [ICCM_BITS-1:1]                    inc_addr;
   iccm_pkg::bank_ctl_t [NUM_BANKS-1:0]     bank_ctl;
   logic [NUM_BANKS-1:0][ROW_BITS-1:0]      bank_addr;
   iccm_pkg::bank_word_t [NUM_BANKS-1:0]    bank_wr_data;
   iccm_pkg::bank_word_t [NUM_BANKS-1:0]    bank_dout;
   logic [NUM_BANKS-1:0]                    red_sel;
   iccm_pkg::bank_word_t [NUM_BANKS-1:0]    red_data;

   // Request bundle shared by steering and redundancy
   assign req = '{wren: wren, rden: rden, correct_ecc: correct_ecc,
                  correction_state: correction_state, wr_size: wr_size, wr_data: wr_data};

   iccm_mem #(.ICCM_BITS(ICCM_BITS), .NUM_BANKS(NUM_BANKS)) u_mem (
      .clk, .reset, .req, .rw_addr, .inc_addr,
      .bank_ctl, .bank_addr, .bank_wr_data, .bank_dout,
      .red_sel, .red_data, .rd_data, .rd_data_ecc
   );

   iccm_redundancy #(.ICCM_BITS(ICCM_BITS), .NUM_BANKS(NUM_BANKS)) u_red (
      .clk, .reset, .req, .rw_addr, .inc_addr, .red_sel, .red_data
   );

   // One RAM per bank
   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
      iccm_bank_ram #(.ROW_BITS(ROW_BITS)) u_bank (
         .clk     (clk),
         .ctl     (bank_ctl[i]),
         .addr    (bank_addr[i]),
         .wr_data (bank_wr_data[i]),
         .dout    (bank_dout[i])
      );
   end

endmodule

// File: include/iccm_tb_cases.svh
//**************************************
// Stimulus table for the ICCM testbench
// Included inside the testbench module, fills the case queue
//**************************************

// Columns: name, op, halfword address, size, data {hi32, lo32}, expected rd_data
// Word ops use the low 32 data bits in both halves, check bits are random
task automatic load_cases();
   // Word writes, one per bank on row 0x10
   add_case("wr_bank0",      OP_WRITE,   11'h080, 3'd0, 64'h0000_0000_0123_4567, 64'h0);
   add_case("wr_bank1",      OP_WRITE,   11'h082, 3'd0, 64'h0000_0000_89AB_CDEF, 64'h0);
   add_case("wr_bank2",      OP_WRITE,   11'h084, 3'd0, 64'h0000_0000_0F1E_2D3C, 64'h0);
   add_case("wr_bank3",      OP_WRITE,   11'h086, 3'd0, 64'h0000_0000_4B5A_6978, 64'h0);
   add_case("rd_pair_b01",   OP_READ,    11'h080, 3'd3, 64'h0, 64'h89AB_CDEF_0123_4567);
   add_case("rd_pair_b23",   OP_READ,    11'h084, 3'd3, 64'h0, 64'h4B5A_6978_0F1E_2D3C);
   add_case("rd_word_b1",    OP_READ,    11'h082, 3'd0, 64'h0, 64'h89AB_CDEF_89AB_CDEF);
   // Odd halfword start
   add_case("rd_shift_b01",  OP_READ,    11'h081, 3'd3, 64'h0, 64'h0000_89AB_CDEF_0123);
   add_case("rd_shift_b12",  OP_READ,    11'h083, 3'd3, 64'h0, 64'h0000_0F1E_2D3C_89AB);
   // Double words, last read pair crosses into row 0x13
   add_case("wr_dw_b01",     OP_WRITE,   11'h090, 3'd3, 64'hCAFE_F00D_DEAD_BEEF, 64'h0);
   add_case("wr_dw_b23",     OP_WRITE,   11'h094, 3'd3, 64'h2468_ACE0_1357_9BDF, 64'h0);
   add_case("wr_dw_next_row",OP_WRITE,   11'h098, 3'd3, 64'h3C3C_C3C3_5555_AAAA, 64'h0);
   add_case("rd_dw_b01",     OP_READ,    11'h090, 3'd3, 64'h0, 64'hCAFE_F00D_DEAD_BEEF);
   add_case("rd_dw_b23",     OP_READ,    11'h094, 3'd3, 64'h0, 64'h2468_ACE0_1357_9BDF);
   add_case("rd_row_cross",  OP_READ,    11'h096, 3'd3, 64'h0, 64'h5555_AAAA_2468_ACE0);
   add_case("rd_row_shift",  OP_READ,    11'h097, 3'd3, 64'h0, 64'h0000_5555_AAAA_2468);
   // Correction then fault on word 0x60
   add_case("fix_a",         OP_CORRECT, 11'h0C0, 3'd0, 64'h0000_0000_A5A5_0060, 64'h0);
   add_case("fault_a",       OP_INJECT,  11'h0C0, 3'd0, 64'h0000_0000_FFFF_0000, 64'h0);
   add_case("rd_a_fixed",    OP_READ,    11'h0C0, 3'd0, 64'h0, 64'hA5A5_0060_A5A5_0060);
   // Two more corrections, row of word 0x60 gets evicted
   add_case("fix_b",         OP_CORRECT, 11'h0CA, 3'd0, 64'h0000_0000_B4B4_0065, 64'h0);
   add_case("fix_c",         OP_CORRECT, 11'h0D4, 3'd0, 64'h0000_0000_C3C3_006A, 64'h0);
   add_case("rd_a_evicted",  OP_READ,    11'h0C0, 3'd0, 64'h0, 64'hFFFF_0000_FFFF_0000);
   add_case("fault_b",       OP_INJECT,  11'h0CA, 3'd0, 64'h0000_0000_0BAD_0065, 64'h0);
   add_case("rd_b_fixed",    OP_READ,    11'h0CA, 3'd0, 64'h0, 64'hB4B4_0065_B4B4_0065);
   // Normal write keeps the row current
   add_case("wr_b_new",      OP_WRITE,   11'h0CA, 3'd0, 64'h0000_0000_600D_0065, 64'h0);
   add_case("fault_b_again", OP_INJECT,  11'h0CA, 3'd0, 64'h0000_0000_DEAD_0065, 64'h0);
   add_case("rd_b_refresh",  OP_READ,    11'h0CA, 3'd0, 64'h0, 64'h600D_0065_600D_0065);
   // Replay hit on row 1 moves LRU to row 0, so word 0x6A goes next
   add_case("replay_b",      OP_REPLAY,  11'h0CA, 3'd0, 64'h0, 64'h600D_0065_600D_0065);
   add_case("fix_d",         OP_CORRECT, 11'h0E0, 3'd0, 64'h0000_0000_D2D2_0070, 64'h0);
   add_case("fault_c",       OP_INJECT,  11'h0D4, 3'd0, 64'h0000_0000_BAD0_006A, 64'h0);
   add_case("rd_c_evicted",  OP_READ,    11'h0D4, 3'd0, 64'h0, 64'hBAD0_006A_BAD0_006A);
   add_case("rd_d_fixed",    OP_READ,    11'h0E0, 3'd0, 64'h0, 64'hD2D2_0070_D2D2_0070);
   add_case("rd_b_kept",     OP_READ,    11'h0CA, 3'd0, 64'h0, 64'h600D_0065_600D_0065);
endtask

// File: test/iccm_tb.sv
//**************************************
// Testbench for the banked ICCM
// Runs the included case table against a memory and
// redundancy model, one access per case, reads checked
// one cycle after rden
//**************************************

`timescale 1ns/1ps

module iccm_tb;

   localparam int ICCM_BITS = 12;                     // Four banks of 256 rows
   localparam int NUM_BANKS = 4;

   typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_REPLAY, OP_CORRECT, OP_INJECT} op_t;

   typedef struct {
      string                name;
      op_t                  op;
      logic [ICCM_BITS-1:1] addr;                     // Halfword address
      iccm_pkg::wr_size_t   size;
      logic [63:0]          data;                     // {hi32, lo32}
      iccm_pkg::rd_data_t   exp;                      // Expected rd_data on reads
   } case_t;

   logic                 clk = 1'b0;
   logic                 reset;
   logic                 wren;
   logic                 rden;
   logic [ICCM_BITS-1:1] rw_addr;
   logic                 correct_ecc;
   logic                 correction_state;
   iccm_pkg::wr_size_t   wr_size;
   iccm_pkg::wr_data_t   wr_data;
   iccm_pkg::rd_data_t   rd_data;
   iccm_pkg::wr_data_t   rd_data_ecc;

   case_t                cases[$];
   integer               seed;
   int                   passed = 0;
   int                   failed = 0;
   int                   cycles = 0;
   int                   limit  = 100;

   //**************************************
   // Reference model state
   //**************************************
   iccm_pkg::bank_word_t model_mem [1 << (ICCM_BITS-2)];   // By word address
   logic [ICCM_BITS-1:2] row_addr  [2];
   iccm_pkg::bank_word_t row_word  [2];
   logic                 row_valid [2] = '{1'b0, 1'b0};
   logic                 model_lru = 1'b0;

   // Bank words corrupted through the backdoor
   iccm_pkg::bank_word_t fault_word [1 << (ICCM_BITS-2)];
   logic                 fault_on   [1 << (ICCM_BITS-2)] = '{default: 1'b0};

   iccm_top #(.ICCM_BITS(ICCM_BITS), .NUM_BANKS(NUM_BANKS)) dut (
      .clk, .reset, .wren, .rden, .rw_addr, .correct_ecc, .correction_state,
      .wr_size, .wr_data, .rd_data, .rd_data_ecc
   );

   always #2 clk = ~clk;                              // 4 ns period

   // Watchdog
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > limit) begin
         $display("Timeout: run did not finish within %0d cycles", limit);
         $display("TESTS FAILED");
         $finish;
      end
   end

   function automatic void add_case(string name, op_t op, logic [ICCM_BITS-1:1] addr,
                                    iccm_pkg::wr_size_t size, logic [63:0] data,
                                    iccm_pkg::rd_data_t exp);
      case_t c;
      c = '{name: name, op: op, addr: addr, size: size, data: data, exp: exp};
      cases.push_back(c);
   endfunction

   `include "iccm_tb_cases.svh"

   // Second access address, one halfword for a word, two for a double word
   function automatic logic [ICCM_BITS-1:1] next_addr(logic [ICCM_BITS-1:1] a,
                                                      iccm_pkg::wr_size_t s);
      logic [ICCM_BITS-1:1] step;
      step = (s == 3'd3) ? (ICCM_BITS-1)'(2) : (ICCM_BITS-1)'(1);
      return a + step;
   endfunction

   // Redundant copy wins over the bank, a corrupted bank word shows otherwise
   function automatic iccm_pkg::bank_word_t read_word(logic [ICCM_BITS-1:2] w);
      if (row_valid[1] && row_addr[1] == w) return row_word[1];
      if (row_valid[0] && row_addr[0] == w) return row_word[0];
      if (fault_on[w]) return fault_word[w];
      return model_mem[w];
   endfunction

   task automatic model_write(logic [ICCM_BITS-1:1] a, iccm_pkg::wr_size_t s,
                              iccm_pkg::wr_data_t d, logic correct);
      logic [ICCM_BITS-1:1] b;
      logic [ICCM_BITS-1:2] lo_w;
      logic [ICCM_BITS-1:2] hi_w;
      logic                 dw;
      b    = next_addr(a, s);
      dw   = (s == 3'd3);
      lo_w = a[ICCM_BITS-1:2];
      hi_w = {a[ICCM_BITS-1:4], b[3:2]};              // Both banks on the rw_addr row
      model_mem[lo_w] = lo_w[2] ? d[77:39] : d[38:0]; // Odd banks take the high word
      model_mem[hi_w] = hi_w[2] ? d[77:39] : d[38:0];
      fault_on[lo_w]  = 1'b0;                         // Bank word overwritten
      fault_on[hi_w]  = 1'b0;
      for (int r = 0; r < 2; r++) begin
         if (row_valid[r] && a[ICCM_BITS-1:3] == row_addr[r][ICCM_BITS-1:3] &&
             (a[2] == row_addr[r][2] || dw)) begin
            row_word[r] = row_addr[r][2] ? d[77:39] : d[38:0];
         end
      end
      if (correct) begin
         row_addr[model_lru]  = lo_w;
         row_word[model_lru]  = d[38:0];              // Splat, either half
         row_valid[model_lru] = 1'b1;
         model_lru            = ~model_lru;
      end
   endtask

   task automatic model_read(input logic [ICCM_BITS-1:1] a, input iccm_pkg::wr_size_t s,
                             input logic cs, output iccm_pkg::wr_data_t pair,
                             output iccm_pkg::rd_data_t rd);
      logic [ICCM_BITS-1:1] b;
      iccm_pkg::bank_word_t lo;
      iccm_pkg::bank_word_t hi;
      logic [63:0]          joined;
      logic                 hit0;
      logic                 hit1;
      b      = next_addr(a, s);
      lo     = read_word(a[ICCM_BITS-1:2]);
      hi     = read_word(b[ICCM_BITS-1:2]);
      pair   = {hi, lo};
      joined = {hi[31:0], lo[31:0]};
      rd     = a[1] ? {16'h0000, joined[63:16]} : joined;
      hit0 = row_valid[0] &&
             (row_addr[0] == a[ICCM_BITS-1:2] || row_addr[0] == b[ICCM_BITS-1:2]);
      hit1 = row_valid[1] &&
             (row_addr[1] == a[ICCM_BITS-1:2] || row_addr[1] == b[ICCM_BITS-1:2]);
      if (cs && (hit0 || hit1)) begin
         model_lru = hit0;                            // Away from the row hit
      end
   endtask

   // Backdoor write into one bank array
   task automatic inject_fault(logic [ICCM_BITS-1:1] a, iccm_pkg::bank_word_t w);
      case (a[3:2])
         2'd0: dut.g_bank[0].u_bank.mem[a[ICCM_BITS-1:4]] = w;
         2'd1: dut.g_bank[1].u_bank.mem[a[ICCM_BITS-1:4]] = w;
         2'd2: dut.g_bank[2].u_bank.mem[a[ICCM_BITS-1:4]] = w;
         default: dut.g_bank[3].u_bank.mem[a[ICCM_BITS-1:4]] = w;
      endcase
      fault_word[a[ICCM_BITS-1:2]] = w;               // Bank now differs from model_mem
      fault_on[a[ICCM_BITS-1:2]]   = 1'b1;
   endtask

   //**************************************
   // One table entry
   //**************************************
   task automatic run_case(case_t c);
      integer               rnd;
      iccm_pkg::bank_word_t lo;
      iccm_pkg::bank_word_t hi;
      iccm_pkg::wr_data_t   pair_exp;
      iccm_pkg::rd_data_t   rd_exp;
      int                   fails;
      fails = 0;
      rnd   = $random(seed);
      lo    = {rnd[6:0], c.data[31:0]};             // Random check bits
      hi    = (c.size == 3'd3) ? {rnd[14:8], c.data[63:32]} : lo;
      @(negedge clk);
      case (c.op)
         OP_WRITE, OP_CORRECT: begin
            wren        = 1'b1;
            correct_ecc = (c.op == OP_CORRECT);
            rw_addr     = c.addr;
            wr_size     = c.size;
            wr_data     = {hi, lo};
            model_write(c.addr, c.size, {hi, lo}, c.op == OP_CORRECT);
         end
         OP_READ, OP_REPLAY: begin
            rden             = 1'b1;
            correction_state = (c.op == OP_REPLAY);
            rw_addr          = c.addr;
            wr_size          = c.size;
            model_read(c.addr, c.size, c.op == OP_REPLAY, pair_exp, rd_exp);
         end
         default: inject_fault(c.addr, lo);          // Model memory keeps the good word
      endcase
      @(negedge clk);                                 // Read data valid here
      if (c.op == OP_READ || c.op == OP_REPLAY) begin
         assert (rd_exp === c.exp) else begin
            $display("Model and table disagree on %s, model gives %h", c.name, rd_exp);
            fails++;
         end
         assert (rd_data === c.exp) else begin
            $display("Error: %s rd_data expected %h actual %h", c.name, c.exp, rd_data);
            fails++;
         end
         assert (rd_data_ecc === pair_exp) else begin
            $display("Error: %s rd_data_ecc expected %h actual %h",
                     c.name, pair_exp, rd_data_ecc);
            fails++;
         end
      end
      wren             = 1'b0;                        // Back to idle
      rden             = 1'b0;
      correct_ecc      = 1'b0;
      correction_state = 1'b0;
      if (fails == 0) begin
         passed++;
         $display("ok    %s", c.name);
      end else begin
         failed++;
      end
   endtask

   initial begin
      seed             = 32'h5084_fead;
      reset            = 1'b1;
      wren             = 1'b0;
      rden             = 1'b0;
      rw_addr          = '0;
      correct_ecc      = 1'b0;
      correction_state = 1'b0;
      wr_size          = '0;
      wr_data          = '0;
      load_cases();
      limit = 20 * cases.size() + 100;
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      foreach (cases[i]) begin
         run_case(cases[i]);
      end
      $display("Summary: %0d tests, %0d passed, %0d failed", cases.size(), passed, failed);
      if (failed == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: iccm.f
+incdir+include
design/iccm_pkg.sv
design/iccm_bank_ram.sv
design/iccm_redundancy.sv
design/iccm_mem.sv
design/iccm_top.sv
test/iccm_tb.sv

// File: Makefile
# Verilator flow for the banked ICCM
# make builds and runs, make lint checks the RTL, make clean tidies up

TOP = iccm_tb
LOG = sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f iccm.f --top-module $(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

lint:
	verilator --lint-only --top-module iccm_top design/iccm_pkg.sv \
		design/iccm_bank_ram.sv design/iccm_redundancy.sv \
		design/iccm_mem.sv design/iccm_top.sv

clean:
	rm -rf obj_dir $(LOG)
